// File: logic/usb1d_pkg.sv
// Shared types, CSR field positions and timeout constants for the USB 1.1 device protocol engine
package usb1d_pkg;

	////////////////////////////////////////////////////////////
	// Protocol engine state
	////////////////////////////////////////////////////////////

	// One-hot encoding, one flop per state
	typedef enum logic [7:0]
	{
		IDLE    = 8'b0000_0001,
		TOKEN   = 8'b0000_0010,
		IN      = 8'b0000_0100,
		IN2     = 8'b0000_1000,
		OUT     = 8'b0001_0000,
		OUT2A   = 8'b0010_0000,
		UPDATEW = 8'b0100_0000,
		UPDATE  = 8'b1000_0000
	} pe_state_t;

	// Handshake select towards the packet assembler
	typedef enum logic [1:0]
	{
		HS_ACK   = 2'd0,
		HS_NACK  = 2'd1,
		HS_STALL = 2'd2,
		HS_NYET  = 2'd3
	} hs_pid_t;

	// Expected data PID for the current endpoint
	typedef logic [1:0] dpid_t;
	localparam dpid_t DPID_DATA0 = 2'd0;
	localparam dpid_t DPID_DATA1 = 2'd1;
	localparam dpid_t DPID_DATA2 = 2'd2;
	localparam dpid_t DPID_MDATA = 2'd3;

	////////////////////////////////////////////////////////////
	// Endpoint CSR fields
	////////////////////////////////////////////////////////////

	localparam int CSR_W       = 14;
	localparam int CSR_IN_EP   = 9;
	localparam int CSR_OUT_EP  = 10;
	localparam int CSR_CTRL_EP = 11;
	// Interrupt transfer when neither ISO nor BULK is set
	localparam int CSR_ISO     = 12;
	localparam int CSR_BULK    = 13;

	// Response timeouts, in clk cycles
	localparam int TO_CNT_W = 8;
	typedef logic [TO_CNT_W-1:0] to_cnt_t;
	localparam to_cnt_t RX_ACK_TO_VAL  = 8'd40;
	localparam to_cnt_t TX_DATA_TO_VAL = 8'd48;

endpackage

// File: logic/pe_tok_if.sv
// Token decoder to protocol FSM link, decoded token kinds forward and busy status back
`timescale 1ns/10ps

interface pe_tok_if;

	// Registered match and function select
	logic match_q;
	// Registered token kinds, valid with match_q
	logic tok_in;
	logic tok_out;
	logic tok_sof;
	// Host ACK seen this cycle
	logic host_ack;
	// Data PID does not follow the expected sequence
	logic seq_err;
	// FSM outside IDLE
	logic busy;

	modport dec
	(
		output match_q, tok_in, tok_out, tok_sof, host_ack, seq_err,
		input  busy
	);

	modport fsm
	(
		input  match_q, tok_in, tok_out, tok_sof, host_ack, seq_err,
		output busy
	);

endinterface

// File: logic/usb1d_pe_tok_dec.sv
// Token intake for the protocol engine that registers matched token kinds and checks data PID order
`timescale 1ns/10ps

module usb1d_pe_tok_dec
(
	input  logic              clk,
	input  logic              rst,
	input  logic              match,
	input  logic              fsel,
	input  logic              token_valid,
	input  logic              pid_in,
	input  logic              pid_out,
	input  logic              pid_setup,
	input  logic              pid_sof,
	input  logic              pid_ack,
	input  logic              pid_data0,
	input  logic              pid_data1,
	input  logic              pid_data2,
	input  logic              pid_mdata,
	input  usb1d_pkg::dpid_t  cfg_this_dpid,
	pe_tok_if.dec             tok,
	output logic              nse_err,
	output logic              abort
);
	import usb1d_pkg::*;

	logic dpid_ok;

	// Incoming data PID against the expected one
	assign dpid_ok = (cfg_this_dpid == DPID_DATA0 && pid_data0) ||
		(cfg_this_dpid == DPID_DATA1 && pid_data1) ||
		(cfg_this_dpid == DPID_DATA2 && pid_data2) ||
		(cfg_this_dpid == DPID_MDATA && pid_mdata);

	// Host ACK goes straight through to IN2
	assign tok.host_ack = token_valid & pid_ack;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			tok.match_q <= 1'b0;
			tok.tok_in  <= 1'b0;
			tok.tok_out <= 1'b0;
			tok.tok_sof <= 1'b0;
			tok.seq_err <= 1'b0;
			nse_err     <= 1'b0;
			abort       <= 1'b0;
		end
		else
		begin
			tok.match_q <= match & fsel;
			// Token kinds land together with match_q
			tok.tok_in  <= token_valid & pid_in;
			tok.tok_out <= token_valid & (pid_out | pid_setup);
			tok.tok_sof <= token_valid & pid_sof;
			// Sampled every cycle and read by the FSM at end of packet
			tok.seq_err <= !dpid_ok;
			// Token for an endpoint this function does not have
			nse_err     <= token_valid & (pid_out | pid_in | pid_setup) & !match;
			// New token while a transfer is still running
			abort       <= match & fsel & tok.busy;
		end
	end

	// Decoded PIDs are exclusive, so IN and OUT never both start a phase
	a_tok_excl: assert property (@(posedge clk) disable iff (!rst)
		!(tok.tok_in && tok.tok_out));

endmodule

// File: logic/usb1d_pe_timer.sv
// Response timeout counter instantiated once per host response the engine waits for
`timescale 1ns/10ps

module usb1d_pe_timer
#(
	parameter usb1d_pkg::to_cnt_t TO_VAL = 8'd40
)
(
	input  logic clk,
	input  logic rst,
	input  logic clr,
	output logic expired
);
	import usb1d_pkg::*;

	to_cnt_t cnt;

	// Free running counter that restarts from zero on clr
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			cnt <= '0;
		else if (clr)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	// Expiry one cycle after the count hits TO_VAL
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			expired <= 1'b0;
		else
			expired <= !clr && (cnt == TO_VAL);
	end

	// Count must have left zero with clr low TO_VAL+1 cycles earlier
	a_exp_after_clr: assert property (@(posedge clk) disable iff (!rst)
		expired |-> !$past(clr, TO_VAL + 1));

endmodule

// File: logic/usb1d_pe_fsm.sv
// Main protocol FSM of the device engine that runs data phase, handshake, DMA gating and interrupts
`timescale 1ns/10ps

module usb1d_pe_fsm
(
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         match,
	input  logic                         tx_valid,
	input  logic                         idma_done,
	input  logic                         rx_data_done,
	input  logic                         crc16_err,
	input  logic                         ep_full,
	input  logic                         ep_empty,
	input  logic                         cfg_send_stall,
	input  logic                         rx_ack_to,
	input  logic                         tx_data_to,
	input  logic [usb1d_pkg::CSR_W-1:0]  cfg_csr,
	pe_tok_if.fsm                        tok,
	input  logic                         abort,
	output logic                         send_token,
	output logic                         rx_dma_en,
	output logic                         tx_dma_en,
	output logic                         int_to_set,
	output logic                         int_crc16_set,
	output logic                         int_seqerr_set,
	output logic                         ep_update,
	output logic                         rx_ack_clr,
	output usb1d_pkg::hs_pid_t           token_pid_sel
);
	import usb1d_pkg::*;

	pe_state_t state;
	pe_state_t next_state;
	hs_pid_t   token_pid_sel_d;
	logic      send_token_d;
	logic      int_seqerr_set_d;
	logic      update_d;
	logic      rx_ack_clr_d;
	logic      send_stall_r;

	// Endpoint and transfer type
	logic in_ep;
	logic out_ep;
	logic ctrl_ep;
	logic txfr_iso;
	logic txfr_int;

	assign in_ep    = cfg_csr[CSR_IN_EP];
	assign out_ep   = cfg_csr[CSR_OUT_EP];
	assign ctrl_ep  = cfg_csr[CSR_CTRL_EP];
	assign txfr_iso = cfg_csr[CSR_ISO];
	assign txfr_int = !cfg_csr[CSR_ISO] && !cfg_csr[CSR_BULK];

	assign tok.busy = (state != IDLE);

	////////////////////////////////////////////////////////////
	// Interrupt set pulses
	////////////////////////////////////////////////////////////

	// Host silent after our data, or no data after an OUT token
	assign int_to_set = (state == IN2 && rx_ack_to) || (state == OUT && tx_data_to);
	assign int_crc16_set = rx_data_done & crc16_err;

	// Stall request held until a handshake goes out
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			send_stall_r <= 1'b0;
		else if (cfg_send_stall)
			send_stall_r <= 1'b1;
		else if (send_token)
			send_stall_r <= 1'b0;
	end

	////////////////////////////////////////////////////////////
	// State and registered outputs
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state          <= IDLE;
			send_token     <= 1'b0;
			token_pid_sel  <= HS_ACK;
			int_seqerr_set <= 1'b0;
			ep_update      <= 1'b0;
			rx_ack_clr     <= 1'b1;
		end
		else
		begin
			// Any matching token restarts the engine
			if (match)
				state <= IDLE;
			else
				state <= next_state;
			send_token     <= send_token_d;
			token_pid_sel  <= token_pid_sel_d;
			int_seqerr_set <= int_seqerr_set_d;
			ep_update      <= update_d;
			// Ack timer runs only in IN and IN2 once tx_valid has dropped
			rx_ack_clr     <= tx_valid | rx_ack_clr_d;
		end
	end

	////////////////////////////////////////////////////////////
	// Next state decode
	////////////////////////////////////////////////////////////

	always_comb
	begin
		next_state       = state;
		token_pid_sel_d  = HS_ACK;
		send_token_d     = 1'b0;
		rx_dma_en        = 1'b0;
		tx_dma_en        = 1'b0;
		update_d         = 1'b0;
		rx_ack_clr_d     = 1'b1;
		int_seqerr_set_d = 1'b0;

		case (state)
			IDLE:
			begin
				// SOF carries no data phase
				if (tok.match_q && !tok.tok_sof)
				begin
					if (in_ep || (ctrl_ep && tok.tok_in))
					begin
						// Nothing to send on interrupt IN
						if (txfr_int && ep_empty)
						begin
							token_pid_sel_d = HS_NACK;
							send_token_d    = 1'b1;
							next_state      = TOKEN;
						end
						else
						begin
							tx_dma_en  = 1'b1;
							next_state = IN;
						end
					end
					else if (out_ep || (ctrl_ep && tok.tok_out))
					begin
						rx_dma_en  = 1'b1;
						next_state = OUT;
					end
				end
			end

			TOKEN:
				next_state = IDLE;

			IN:
			begin
				rx_ack_clr_d = 1'b0;
				// Iso IN expects no ACK
				if (idma_done)
					next_state = txfr_iso ? UPDATE : IN2;
			end

			IN2:
			begin
				rx_ack_clr_d = 1'b0;
				if (rx_ack_to)
					next_state = IDLE;
				else if (tok.host_ack)
					next_state = UPDATE;
			end

			OUT:
			begin
				if (tx_data_to || crc16_err || abort)
					next_state = IDLE;
				else if (rx_data_done)
				begin
					// Iso OUT sends no handshake and only flags a sequence error
					if (txfr_iso)
					begin
						int_seqerr_set_d = tok.seq_err;
						next_state       = UPDATEW;
					end
					else
						next_state = OUT2A;
				end
			end

			OUT2A:
			begin
				// Handshake priority is STALL, then NACK, then ACK
				if (abort)
					next_state = IDLE;
				else if (send_stall_r)
				begin
					token_pid_sel_d = HS_STALL;
					send_token_d    = 1'b1;
					next_state      = IDLE;
				end
				else if (ep_full)
				begin
					token_pid_sel_d = HS_NACK;
					send_token_d    = 1'b1;
					next_state      = IDLE;
				end
				else
				begin
					token_pid_sel_d = HS_ACK;
					send_token_d    = 1'b1;
					// Repeated packet is acked but not stored
					next_state      = tok.seq_err ? IDLE : UPDATE;
				end
			end

			UPDATEW:
				next_state = UPDATE;

			UPDATE:
			begin
				update_d   = 1'b1;
				next_state = IDLE;
			end

			default:
				next_state = IDLE;
		endcase
	end

	a_state_onehot: assert property (@(posedge clk) disable iff (!rst)
		$onehot(state));

	a_token_single: assert property (@(posedge clk) disable iff (!rst)
		send_token |=> !send_token);

	a_dma_excl: assert property (@(posedge clk) disable iff (!rst)
		!(rx_dma_en && tx_dma_en));

endmodule

// File: logic/usb1d_pe.sv
// Top level of the USB 1.1 device protocol engine joining token decoder, timers and FSM
`timescale 1ns/10ps

module usb1d_pe
(
	input  logic                         clk,
	input  logic                         rst,

	// UTMI side
	input  logic                         tx_valid,
	input  logic                         rx_active,

	// Decoded PIDs valid with token_valid or rx_data_done
	input  logic                         pid_out,
	input  logic                         pid_in,
	input  logic                         pid_sof,
	input  logic                         pid_setup,
	input  logic                         pid_data0,
	input  logic                         pid_data1,
	input  logic                         pid_data2,
	input  logic                         pid_mdata,
	input  logic                         pid_ack,
	input  logic                         pid_ping,
	input  logic                         token_valid,

	// Receive data
	input  logic                         rx_data_done,
	input  logic                         crc16_err,

	// Packet assembler
	output logic                         send_token,
	output usb1d_pkg::hs_pid_t           token_pid_sel,

	// DMA
	output logic                         rx_dma_en,
	output logic                         tx_dma_en,
	output logic                         abort,
	input  logic                         idma_done,

	// Register file
	input  logic                         fsel,
	input  logic                         match,
	output logic                         nse_err,
	input  logic                         ep_full,
	input  logic                         ep_empty,
	output logic                         int_crc16_set,
	output logic                         int_to_set,
	output logic                         int_seqerr_set,
	output logic                         ep_update,
	input  logic [usb1d_pkg::CSR_W-1:0]  cfg_csr,
	input  logic                         cfg_send_stall,
	input  usb1d_pkg::dpid_t             cfg_this_dpid
);
	import usb1d_pkg::*;

	logic rx_ack_clr;
	logic rx_ack_to;
	logic tx_data_to;

	pe_tok_if i_tok ();

	////////////////////////////////////////////////////////////
	// Token decode
	////////////////////////////////////////////////////////////

	// PING addresses an OUT endpoint and decodes as an OUT token
	usb1d_pe_tok_dec i_tok_dec
	(
		.clk           (clk),
		.rst           (rst),
		.match         (match),
		.fsel          (fsel),
		.token_valid   (token_valid),
		.pid_in        (pid_in),
		.pid_out       (pid_out | pid_ping),
		.pid_setup     (pid_setup),
		.pid_sof       (pid_sof),
		.pid_ack       (pid_ack),
		.pid_data0     (pid_data0),
		.pid_data1     (pid_data1),
		.pid_data2     (pid_data2),
		.pid_mdata     (pid_mdata),
		.cfg_this_dpid (cfg_this_dpid),
		.tok           (i_tok.dec),
		.nse_err       (nse_err),
		.abort         (abort)
	);

	////////////////////////////////////////////////////////////
	// Response timers
	////////////////////////////////////////////////////////////

	// Host ACK after our IN data
	usb1d_pe_timer #(.TO_VAL(RX_ACK_TO_VAL)) i_rx_ack_to
	(
		.clk     (clk),
		.rst     (rst),
		.clr     (rx_ack_clr),
		.expired (rx_ack_to)
	);

	// OUT data packet wait restarted by every rx_active
	usb1d_pe_timer #(.TO_VAL(TX_DATA_TO_VAL)) i_tx_data_to
	(
		.clk     (clk),
		.rst     (rst),
		.clr     (rx_active),
		.expired (tx_data_to)
	);

	usb1d_pe_fsm i_fsm
	(
		.clk            (clk),
		.rst            (rst),
		.match          (match),
		.tx_valid       (tx_valid),
		.idma_done      (idma_done),
		.rx_data_done   (rx_data_done),
		.crc16_err      (crc16_err),
		.ep_full        (ep_full),
		.ep_empty       (ep_empty),
		.cfg_send_stall (cfg_send_stall),
		.rx_ack_to      (rx_ack_to),
		.tx_data_to     (tx_data_to),
		.cfg_csr        (cfg_csr),
		.tok            (i_tok.fsm),
		.abort          (abort),
		.send_token     (send_token),
		.rx_dma_en      (rx_dma_en),
		.tx_dma_en      (tx_dma_en),
		.int_to_set     (int_to_set),
		.int_crc16_set  (int_crc16_set),
		.int_seqerr_set (int_seqerr_set),
		.ep_update      (ep_update),
		.rx_ack_clr     (rx_ack_clr),
		.token_pid_sel  (token_pid_sel)
	);

endmodule

// File: tb/pe_host_tasks.svh
// Host-side stimulus tasks and expected-result model included inside the protocol engine testbench
`ifndef PE_HOST_TASKS_SVH
`define PE_HOST_TASKS_SVH

// Token strobe of kind 0 IN, 1 OUT or 2 SETUP
task issue_token(input int kind, input bit m);
	@(posedge clk);
	token_valid <= 1'b1;
	match       <= m;
	fsel        <= 1'b1;
	pid_in      <= (kind == 0);
	pid_out     <= (kind == 1);
	pid_setup   <= (kind == 2);
	@(posedge clk);
	token_valid <= 1'b0;
	match       <= 1'b0;
	pid_in      <= 1'b0;
	pid_out     <= 1'b0;
	pid_setup   <= 1'b0;
endtask

// Host handshake after IN data, sent without an address match
task issue_ack;
	@(posedge clk);
	token_valid <= 1'b1;
	pid_ack     <= 1'b1;
	@(posedge clk);
	token_valid <= 1'b0;
	pid_ack     <= 1'b0;
endtask

task pulse_idma_done;
	@(posedge clk);
	idma_done <= 1'b1;
	@(posedge clk);
	idma_done <= 1'b0;
endtask

// End of an OUT data packet where bad selects a CRC16 error
task pulse_rx_data_done(input bit bad);
	@(posedge clk);
	rx_data_done <= 1'b1;
	crc16_err    <= bad;
	@(posedge clk);
	rx_data_done <= 1'b0;
	crc16_err    <= 1'b0;
endtask

// Data PID lines held for the whole packet
task set_data_pid(input dpid_t exp, input bit wrong);
	dpid_t sent;
	sent = wrong ? (exp ^ 2'd1) : exp;
	@(posedge clk);
	pid_data0 <= (sent == 2'd0);
	pid_data1 <= (sent == 2'd1);
	pid_data2 <= (sent == 2'd2);
	pid_mdata <= (sent == 2'd3);
endtask

////////////////////////////////////////////////////////////
// Expected results
////////////////////////////////////////////////////////////

// STALL first, then NACK on a full buffer
function hs_pid_t expect_out_hs(input bit stall, input bit full);
	if (stall)
		return HS_STALL;
	else if (full)
		return HS_NACK;
	return HS_ACK;
endfunction

// Iso always stores and other types store only acked in-sequence data
function int expect_out_update(input hs_pid_t hs, input bit wrong, input bit iso);
	if (iso)
		return 1;
	return (hs == HS_ACK && !wrong) ? 1 : 0;
endfunction

function int expect_in_update(input bit iso, input bit silent);
	return (iso || !silent) ? 1 : 0;
endfunction

`endif

// File: tb/tb_usb1d_pe.sv
// Testbench for the protocol engine driving random IN/OUT/error transactions against a host model
`timescale 1ns/10ps

module tb_usb1d_pe;
	import usb1d_pkg::*;

	logic clk;
	logic rst;
	logic tx_valid, rx_active, token_valid, rx_data_done, crc16_err, idma_done;
	logic pid_out, pid_in, pid_sof, pid_setup, pid_ack, pid_ping;
	logic pid_data0, pid_data1, pid_data2, pid_mdata;
	logic fsel, match, ep_full, ep_empty, cfg_send_stall;
	logic [CSR_W-1:0] cfg_csr;
	dpid_t cfg_this_dpid;
	logic send_token, rx_dma_en, tx_dma_en, abort, nse_err;
	logic int_crc16_set, int_to_set, int_seqerr_set, ep_update;
	hs_pid_t token_pid_sel;

	// Monitor counts and model state
	int n_tx_dma, n_rx_dma, n_tok, n_upd, n_to, n_crc, n_seq, n_nse, n_abort;
	int cyc, tok_cyc, rdd_cyc;
	hs_pid_t tok_pid;
	bit stall_latched;
	integer seed;
	int errors, npass;
	bit bad;

	usb1d_pe i_dut (.*);

	`include "pe_host_tasks.svh"

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	// Output monitor sampled mid-cycle
	always @(negedge clk)
	begin
		if (tx_dma_en) n_tx_dma++;
		if (rx_dma_en) n_rx_dma++;
		if (ep_update) n_upd++;
		if (int_to_set) n_to++;
		if (int_crc16_set) n_crc++;
		if (int_seqerr_set) n_seq++;
		if (nse_err) n_nse++;
		if (abort) n_abort++;
		if (send_token)
		begin
			n_tok++;
			tok_cyc = cyc;
			tok_pid = token_pid_sel;
		end
		if (rx_data_done)
			rdd_cyc = cyc;
		// Stall request sticks until a handshake is sent
		if (cfg_send_stall)
			stall_latched = 1'b1;
		else if (send_token)
			stall_latched = 1'b0;
	end

	function int rnd(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	task clear_counts;
		n_tx_dma = 0;
		n_rx_dma = 0;
		n_tok = 0;
		n_upd = 0;
		n_to = 0;
		n_crc = 0;
		n_seq = 0;
		n_nse = 0;
		n_abort = 0;
	endtask

	task idle_cycles(input int n);
		repeat (n) @(negedge clk);
		#1;
	endtask

	task check_value(input string sig, input int got, input int exp);
		if (got != exp)
		begin
			$display("FAIL %0t %s got %0d expected %0d", $time, sig, got, exp);
			errors++;
			bad = 1'b1;
		end
	endtask

	// Event select 0 tx_dma_en, 1 rx_dma_en, 2 send_token, 3 ep_update, 4 int_to_set
	task wait_event(input int which, input int limit, input string what);
		int n;
		bit seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < limit)
		begin
			@(negedge clk);
			#1;
			n++;
			case (which)
				0: seen = (n_tx_dma > 0);
				1: seen = (n_rx_dma > 0);
				2: seen = (n_tok > 0);
				3: seen = (n_upd > 0);
				default: seen = (n_to > 0);
			endcase
		end
		if (!seen)
		begin
			$display("Timeout after %0d cycles waiting for %s", limit, what);
			errors++;
			bad = 1'b1;
		end
	endtask

	task apply_cfg(input logic [CSR_W-1:0] csr, input bit empty, input bit full,
		input dpid_t dp, input bit stall);
		@(posedge clk);
		cfg_csr        <= csr;
		ep_empty       <= empty;
		ep_full        <= full;
		cfg_this_dpid  <= dp;
		cfg_send_stall <= stall;
		@(posedge clk);
		cfg_send_stall <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// One random transaction
	////////////////////////////////////////////////////////////

	task run_transaction(input int idx);
		int kind, host;
		bit stall, full, wrong, iso;
		dpid_t edp;
		hs_pid_t hs;
		logic [CSR_W-1:0] csr;
		string name;
		kind  = rnd(5);
		host  = rnd(3);
		stall = (rnd(4) == 0);
		full  = (rnd(3) == 0);
		wrong = (rnd(4) == 0);
		edp   = dpid_t'(rnd(4));
		csr   = '0;
		// Transfer type 0 bulk, 1 iso, 2 interrupt
		case (rnd(3))
			0: csr[CSR_BULK] = 1'b1;
			1: csr[CSR_ISO] = 1'b1;
			default: ;
		endcase
		iso = csr[CSR_ISO];
		bad = 1'b0;
		clear_counts();
		case (kind)
			0:
			begin
				name = "in";
				csr[CSR_IN_EP] = 1'b1;
				apply_cfg(csr, 1'b0, 1'b0, edp, 1'b0);
				issue_token(0, 1'b1);
				wait_event(0, 10, "tx_dma_en");
				idle_cycles(1 + rnd(8));
				pulse_idma_done();
				if (iso)
					wait_event(3, 10, "ep_update");
				else if (host == 1)
					wait_event(4, 2 * RX_ACK_TO_VAL, "int_to_set");
				else
				begin
					idle_cycles(2);
					issue_ack();
					wait_event(3, 10, "ep_update");
				end
				idle_cycles(4);
				check_value("ep_update", n_upd, expect_in_update(iso, host == 1));
				check_value("int_to_set", n_to, (!iso && host == 1) ? 1 : 0);
			end
			1:
			begin
				name = "in_nak";
				csr = '0;
				csr[CSR_IN_EP] = 1'b1;
				apply_cfg(csr, 1'b1, 1'b0, edp, 1'b0);
				issue_token(0, 1'b1);
				wait_event(2, 10, "send_token");
				check_value("token_pid_sel", tok_pid, HS_NACK);
				idle_cycles(4);
				check_value("tx_dma_en", n_tx_dma, 0);
				check_value("ep_update", n_upd, 0);
			end
			2:
			begin
				name = "out";
				csr[CSR_OUT_EP] = 1'b1;
				set_data_pid(edp, wrong);
				apply_cfg(csr, 1'b0, full, edp, stall);
				if (host == 1)
					rx_active <= 1'b0;
				issue_token(1 + rnd(2), 1'b1);
				wait_event(1, 10, "rx_dma_en");
				if (host == 1)
				begin
					wait_event(4, 2 * TX_DATA_TO_VAL, "int_to_set");
					@(posedge clk);
					rx_active <= 1'b1;
					idle_cycles(4);
					check_value("int_to_set", n_to, 1);
					check_value("ep_update", n_upd, 0);
					check_value("send_token", n_tok, 0);
				end
				else if (host == 2)
				begin
					idle_cycles(2);
					pulse_rx_data_done(1'b1);
					idle_cycles(4);
					check_value("int_crc16_set", n_crc, 1);
					check_value("send_token", n_tok, 0);
					check_value("ep_update", n_upd, 0);
				end
				else
				begin
					idle_cycles(2);
					hs = expect_out_hs(stall_latched, full);
					pulse_rx_data_done(1'b0);
					if (iso)
					begin
						wait_event(3, 10, "ep_update");
						idle_cycles(4);
						check_value("int_seqerr_set", n_seq, wrong);
						check_value("send_token", n_tok, 0);
					end
					else
					begin
						wait_event(2, 10, "send_token");
						check_value("send_token delay", tok_cyc - rdd_cyc, 2);
						check_value("token_pid_sel", tok_pid, hs);
						idle_cycles(4);
						check_value("send_token", n_tok, 1);
					end
					check_value("ep_update", n_upd, expect_out_update(hs, wrong, iso));
				end
			end
			3:
			begin
				name = "nse";
				csr[CSR_OUT_EP] = 1'b1;
				apply_cfg(csr, 1'b0, 1'b0, edp, 1'b0);
				issue_token(rnd(3), 1'b0);
				idle_cycles(4);
				check_value("nse_err", n_nse, 1);
				check_value("rx_dma_en", n_rx_dma, 0);
				check_value("tx_dma_en", n_tx_dma, 0);
			end
			default:
			begin
				name = "abort";
				csr[CSR_OUT_EP] = 1'b1;
				apply_cfg(csr, 1'b0, 1'b0, edp, 1'b0);
				issue_token(1, 1'b1);
				wait_event(1, 10, "rx_dma_en");
				idle_cycles(2);
				issue_token(1, 1'b1);
				idle_cycles(3);
				check_value("abort", n_abort, 1);
				// New token restarts the data phase
				check_value("rx_dma_en", n_rx_dma, 2);
				// Second transfer ends on a bad packet
				pulse_rx_data_done(1'b1);
				idle_cycles(4);
				check_value("ep_update", n_upd, 0);
			end
		endcase
		idle_cycles(3);
		if (!bad)
			npass++;
		$display("test %0d %s %s", idx, name, bad ? "failed" : "ok");
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		seed = 32'h3839_1cb1;
		errors = 0;
		npass = 0;
		cyc = 0;
		stall_latched = 1'b0;
		rst <= 1'b0;
		{tx_valid, token_valid, rx_data_done, crc16_err, idma_done} <= '0;
		{pid_out, pid_in, pid_sof, pid_setup, pid_ack, pid_ping} <= '0;
		{pid_data0, pid_data1, pid_data2, pid_mdata} <= '0;
		{fsel, match, ep_full, ep_empty, cfg_send_stall} <= '0;
		rx_active <= 1'b1;
		cfg_csr <= '0;
		cfg_this_dpid <= '0;
		repeat (3) @(posedge clk);
		rst <= 1'b1;
		bad = 1'b0;
		clear_counts();
		idle_cycles(8);
		check_value("send_token", n_tok, 0);
		check_value("ep_update", n_upd, 0);
		check_value("dma enables", n_tx_dma + n_rx_dma, 0);
		check_value("abort", n_abort + n_nse, 0);
		check_value("interrupts", n_to + n_crc + n_seq, 0);
		if (!bad)
			npass++;
		$display("test 0 reset %s", bad ? "failed" : "ok");
		for (int i = 1; i <= 200; i++)
			run_transaction(i);
		$display("tests 201, passed %0d, errors %0d", npass, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: tb.f
+incdir+tb
logic/usb1d_pkg.sv
logic/pe_tok_if.sv
logic/usb1d_pe_tok_dec.sv
logic/usb1d_pe_timer.sv
logic/usb1d_pe_fsm.sv
logic/usb1d_pe.sv
tb/tb_usb1d_pe.sv

// File: run.sh
#!/bin/sh
# Build and run the protocol engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_usb1d_pe -f tb.f -o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	&& grep -q "^NO ERRORS$" sim.log \
	&& echo "simulation passed" && exit 0 \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }
